// File: Makefile
TOP = pipeCoreTb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --assert --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: flist.f
rtl/cpuPkg.sv
rtl/instDecoder.sv
rtl/regFile.sv
rtl/execUnit.sv
rtl/dataMem.sv
rtl/pipeCore.sv
sim/pipeCore_assert.sv
sim/pipeCoreTb.sv

// File: rtl/cpuPkg.sv
package cpuPkg;

    // widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [5:0]  memIdx_t;   // address bits 8..3

    localparam int      NumRegs  = 32;
    localparam int      MemWords = 64;
    localparam regIdx_t ZeroReg  = 5'd31;

    // R-type and D-type opcodes, bits 31..21
    localparam logic [10:0] OpAdd  = 11'b10001011000;
    localparam logic [10:0] OpSub  = 11'b11001011000;
    localparam logic [10:0] OpAnd  = 11'b10001010000;
    localparam logic [10:0] OpOrr  = 11'b10101010000;
    localparam logic [10:0] OpEor  = 11'b11001010000;
    localparam logic [10:0] OpLdur = 11'b11111000010;
    localparam logic [10:0] OpStur = 11'b11111000000;

    // I-type opcodes, bits 31..22 only
    localparam logic [9:0] OpAddi = 10'b1001000100;
    localparam logic [9:0] OpSubi = 10'b1101000100;
    localparam logic [9:0] OpAndi = 10'b1001001000;
    localparam logic [9:0] OpOrri = 10'b1011001000;
    localparam logic [9:0] OpEori = 10'b1101001000;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOrr,
        AluEor
    } aluOp_t;

    typedef struct packed {
        logic    valid;
        logic    regWrite;   // already cleared for rd == 31
        logic    memRead;
        logic    memWrite;
        logic    useImm;
        aluOp_t  aluOp;
        regIdx_t rn;
        regIdx_t rm;         // second read port, rd for STUR
        regIdx_t rd;
        word_t   imm;
    } decoded_t;

    typedef struct packed {
        logic    valid;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    useImm;
        aluOp_t  aluOp;
        regIdx_t rd;
        word_t   imm;
        word_t   opA;
        word_t   opB;
    } idEx_t;

    typedef struct packed {
        logic    valid;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        regIdx_t rd;
        word_t   result;     // ALU result, also the memory address
        word_t   storeData;
    } exMem_t;

    typedef struct packed {
        logic    valid;
        regIdx_t rd;
        word_t   data;
    } wbPort_t;

endpackage

// File: rtl/dataMem.sv
`timescale 1ns/1ps

module dataMem (
    input  logic          clk,
    input  cpuPkg::word_t addr,
    input  logic          wrEn,
    input  cpuPkg::word_t wrData,
    output cpuPkg::word_t rdData
);
    import cpuPkg::*;

    word_t   mem [MemWords];
    memIdx_t idx;

    assign idx    = addr[8:3];   // doubleword index, low bits ignored
    assign rdData = mem[idx];    // combinational read for LDUR

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[idx] <= wrData;
        end
    end

endmodule

// File: rtl/execUnit.sv
`timescale 1ns/1ps

module execUnit (
    input  cpuPkg::idEx_t ex,
    output cpuPkg::word_t res,
    output cpuPkg::word_t storeData
);
    import cpuPkg::*;

    word_t operandB;

    assign operandB  = ex.useImm ? ex.imm : ex.opB;
    assign storeData = ex.opB;   // STUR value rides along to memory

    // loads and stores use AluAdd for base + offset
    always_comb begin
        case (ex.aluOp)
            AluAdd: begin
                res = ex.opA + operandB;
            end
            AluSub: begin
                res = ex.opA - operandB;
            end
            AluAnd: begin
                res = ex.opA & operandB;
            end
            AluOrr: begin
                res = ex.opA | operandB;
            end
            AluEor: begin
                res = ex.opA ^ operandB;
            end
            default: begin
                res = '0;
            end
        endcase
    end

endmodule

// File: rtl/instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
    input  cpuPkg::instr_t   inst,
    input  logic             instValid,
    output cpuPkg::decoded_t dec
);
    import cpuPkg::*;

    logic [10:0] opc11;
    logic [9:0]  opc10;
    word_t       iImm;
    word_t       dOffset;
    logic        known;
    logic        writesReg;

    assign opc11   = inst[31:21];
    assign opc10   = inst[31:22];
    assign iImm    = {20'b0, inst[21:10]};            // zero-extended
    assign dOffset = {{23{inst[20]}}, inst[20:12]};   // signed 9-bit offset

    always_comb begin
        known     = 1'b1;
        writesReg = 1'b1;
        dec       = '0;
        dec.rd    = inst[4:0];
        dec.rn    = inst[9:5];
        dec.rm    = inst[20:16];
        dec.aluOp = AluAdd;

        case (opc11)
            OpAdd: dec.aluOp = AluAdd;
            OpSub: dec.aluOp = AluSub;
            OpAnd: dec.aluOp = AluAnd;
            OpOrr: dec.aluOp = AluOrr;
            OpEor: dec.aluOp = AluEor;
            OpLdur: begin
                dec.memRead = 1'b1;
                dec.useImm  = 1'b1;
                dec.imm     = dOffset;
            end
            OpStur: begin
                writesReg    = 1'b0;
                dec.memWrite = 1'b1;
                dec.useImm   = 1'b1;
                dec.imm      = dOffset;
                dec.rm       = inst[4:0];   // store value comes from rd field
            end
            default: begin
                // only the I-type group is left, matched on 10 bits
                dec.useImm = 1'b1;
                dec.imm    = iImm;
                case (opc10)
                    OpAddi: dec.aluOp = AluAdd;
                    OpSubi: dec.aluOp = AluSub;
                    OpAndi: dec.aluOp = AluAnd;
                    OpOrri: dec.aluOp = AluOrr;
                    OpEori: dec.aluOp = AluEor;
                    default: begin
                        known      = 1'b0;   // unknown opcode becomes a bubble
                        writesReg  = 1'b0;
                        dec.useImm = 1'b0;
                    end
                endcase
            end
        endcase

        dec.valid    = instValid & known;
        dec.regWrite = writesReg & (dec.rd != ZeroReg);
    end

endmodule

// File: rtl/pipeCore.sv
`timescale 1ns/1ps

module pipeCore (
    input  logic            clk,
    input  logic            rstN,
    input  logic            instValid,
    input  cpuPkg::instr_t  inst,
    output cpuPkg::wbPort_t wb
);
    import cpuPkg::*;

    logic     ifValid;
    instr_t   ifInst;
    decoded_t dec;
    word_t    rdDataA;
    word_t    rdDataB;
    idEx_t    idExD;
    idEx_t    idEx;
    word_t    exRes;
    word_t    exStore;
    exMem_t   exMemD;
    exMem_t   exMem;
    word_t    memRdData;
    wbPort_t  wbD;

    // fetch register, edge 1
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ifValid <= 1'b0;
        end else begin
            ifValid <= instValid;
        end
        ifInst <= inst;
    end

    instDecoder uDecoder (
        .inst      (ifInst),
        .instValid (ifValid),
        .dec       (dec)
    );

    regFile uRegFile (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (dec.rn),
        .rdAddrB (dec.rm),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wr      (wb)      // written one edge after wb shows up
    );

    always_comb begin
        idExD          = '0;
        idExD.valid    = dec.valid;
        idExD.regWrite = dec.regWrite;
        idExD.memRead  = dec.memRead;
        idExD.memWrite = dec.memWrite;
        idExD.useImm   = dec.useImm;
        idExD.aluOp    = dec.aluOp;
        idExD.rd       = dec.rd;
        idExD.imm      = dec.imm;
        idExD.opA      = rdDataA;
        idExD.opB      = rdDataB;
    end

    execUnit uExec (
        .ex        (idEx),
        .res       (exRes),
        .storeData (exStore)
    );

    always_comb begin
        exMemD           = '0;
        exMemD.valid     = idEx.valid;
        exMemD.regWrite  = idEx.regWrite;
        exMemD.memRead   = idEx.memRead;
        exMemD.memWrite  = idEx.memWrite;
        exMemD.rd        = idEx.rd;
        exMemD.result    = exRes;
        exMemD.storeData = exStore;
    end

    // STUR lands on the same edge that loads the wb register
    dataMem uDataMem (
        .clk    (clk),
        .addr   (exMem.result),
        .wrEn   (exMem.valid & exMem.memWrite),
        .wrData (exMem.storeData),
        .rdData (memRdData)
    );

    assign wbD.valid = exMem.valid & exMem.regWrite;
    assign wbD.rd    = exMem.rd;
    assign wbD.data  = exMem.memRead ? memRdData : exMem.result;

    // decode/execute, execute/memory and memory/write-back registers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            idEx.valid  <= 1'b0;
            exMem.valid <= 1'b0;
            wb.valid    <= 1'b0;
        end else begin
            idEx  <= idExD;
            exMem <= exMemD;
            wb    <= wbD;
        end
    end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::regIdx_t rdAddrA,
    input  cpuPkg::regIdx_t rdAddrB,
    output cpuPkg::word_t   rdDataA,
    output cpuPkg::word_t   rdDataB,
    input  cpuPkg::wbPort_t wr
);
    import cpuPkg::*;

    word_t regs [NumRegs];
    logic  hitA;
    logic  hitB;

    // write-through so a reader in the write cycle sees the new value
    assign hitA = wr.valid && (wr.rd == rdAddrA) && (rdAddrA != ZeroReg);
    assign hitB = wr.valid && (wr.rd == rdAddrB) && (rdAddrB != ZeroReg);

    assign rdDataA = hitA ? wr.data : regs[rdAddrA];
    assign rdDataB = hitB ? wr.data : regs[rdAddrB];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                if (regIdx_t'(i) == ZeroReg) begin
                    regs[i] <= '0;
                end else begin
                    regs[i] <= word_t'(i);   // register i starts out holding i
                end
            end
        end else if (wr.valid && (wr.rd != ZeroReg)) begin
            regs[wr.rd] <= wr.data;
        end
    end

endmodule

// File: sim/pipeCorePatterns.txt
# I <instruction hex> issues one instruction and B issues a bubble
# E <rd hex> <data hex> is the next expected write-back
# r-type on reset values back to back
I 8B05006A
E 0A 00000008
I CB04012B
E 0B 00000005
I 8A0600EC
E 0C 00000006
I AA06012D
E 0D 0000000F
I CA0500EE
E 0E 00000002
I CB08004F
E 0F FFFFFFFA
# i-type with zero-extended immediates
I 913FFC30
E 10 00001000
I D1001691
E 11 0000000F
I 9203C3D2
E 12 00000010
I B2200113
E 13 00000808
I D22AF375
E 15 00000AA7
# consumers exactly three slots after their producers
I 91040056
E 16 00000102
B
I AA0C0179
E 19 00000007
I 8B160157
E 17 0000010A
I CA0E01BA
E 1A 0000000D
I D1000738
E 18 00000006
# store then load at X16 minus 16
I F81F020F
I F85F021B
E 1B FFFFFFFA
# write to X31 and an unknown opcode, then reads of X31
I 8B02003F
I DEADBEEF
B
I 8B0903FD
E 1D 00000009
I CA1F013E
E 1E 00000009

// File: sim/pipeCoreTb.sv
`timescale 1ns/1ps

module pipeCoreTb;
    import cpuPkg::*;

    typedef struct packed {
        logic   valid;
        instr_t inst;
    } stim_t;

    typedef struct packed {
        regIdx_t rd;
        word_t   data;
    } expect_t;

    logic    clk;
    logic    rstN;
    logic    instValid;
    instr_t  inst;
    wbPort_t wb;

    stim_t   stimQ [$];   // issue slots, bubbles included
    expect_t expQ [$];    // write-backs in order
    int      errors;

    pipeCore dut (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .inst      (inst),
        .wb        (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reads I, B and E records and skips comment lines
    task automatic loadPatterns();
        int               fd;
        int               n;
        logic [7:0]       kind;
        logic [31:0]      rdVal;
        word_t            dataVal;
        logic [8*128-1:0] rest;
        logic             done;
        fd = $fopen("sim/pipeCorePatterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file sim/pipeCorePatterns.txt");
            errors++;
            return;
        end
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1) begin
                done = 1'b1;
            end else if (kind == "I") begin
                n = $fscanf(fd, "%h", dataVal);
                stimQ.push_back({1'b1, dataVal});
            end else if (kind == "B") begin
                stimQ.push_back({1'b0, 32'h0});
            end else if (kind == "E") begin
                n = $fscanf(fd, "%h %h", rdVal, dataVal);
                expQ.push_back({rdVal[4:0], dataVal});
            end else begin
                n = $fgets(rest, fd);
            end
        end
        $fclose(fd);
        if (expQ.size() == 0) begin
            $display("the pattern file holds no expected write-backs");
            errors++;
        end
    endtask

    task automatic checkWriteBack();
        expect_t want;
        if (expQ.size() == 0) begin
            $display("unexpected write-back to register %0d with data %h", wb.rd, wb.data);
            errors++;
        end else begin
            want = expQ.pop_front();
            if (wb.rd != want.rd) begin
                $display("CHECK FAILED wb.rd expected %h got %h", want.rd, wb.rd);
                errors++;
            end
            if (wb.data != want.data) begin
                $display("CHECK FAILED wb.data expected %h got %h", want.data, wb.data);
                errors++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rstN && wb.valid) begin   // wb is steady mid-cycle
            checkWriteBack();
        end
    end

    initial begin
        int    waitCycles;
        stim_t slot;
        errors = 0;
        rstN      <= 1'b0;
        instValid <= 1'b0;
        inst      <= '0;
        loadPatterns();

        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        while (stimQ.size() != 0) begin
            @(posedge clk);
            slot = stimQ.pop_front();
            instValid <= slot.valid;
            inst      <= slot.inst;
        end
        @(posedge clk);
        instValid <= 1'b0;
        inst      <= '0;

        waitCycles = 0;
        while (expQ.size() != 0 && waitCycles < 20) begin
            @(posedge clk);
            waitCycles++;
        end
        if (expQ.size() != 0) begin
            $display("timed out with %0d expected write-backs never seen", expQ.size());
            errors = errors + expQ.size();
        end
        repeat (8) @(posedge clk);   // room for stray write-backs

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sim/pipeCore_assert.sv
`timescale 1ns/1ps

module pipeCore_assert (
    input logic            clk,
    input logic            rstN,
    input logic            instValid,
    input cpuPkg::wbPort_t wb
);
    import cpuPkg::*;

    // synchronous reset clears wb one edge later
    resetClearsWb: assert property (@(posedge clk) !rstN |=> !wb.valid)
        else $error("wb.valid high while reset is applied");

    // fetch, decode/execute, execute/memory and write-back registers
    wbFollowsIssue: assert property (
        @(posedge clk) disable iff (!rstN) wb.valid |-> $past(instValid, 4)
    ) else $error("wb.valid without an instruction four edges earlier");

    noZeroRegWb: assert property (
        @(posedge clk) disable iff (!rstN) wb.valid |-> (wb.rd != ZeroReg)
    ) else $error("write-back to register 31 seen on wb");

endmodule

bind pipeCore pipeCore_assert uAssert (
    .clk       (clk),
    .rstN      (rstN),
    .instValid (instValid),
    .wb        (wb)
);
